//--- files.f
+incdir+.
rt_pkg.sv
rt_isolate.sv
rt_burst_splitter.sv
rt_addr_decode.sv
rt_budget_counter.sv
rt_budget_bank.sv
rt_unit.sv
tb_rt_unit.sv

//--- rt_addr_decode.sv
/*
  combinational address to region lookup
  overlapping rules resolve to the highest-numbered match
  no match gives region zero with dec_error_o set
*/
`timescale 1ns/1ns
`include "rt_settings.svh"

module rt_addr_decode import rt_pkg::*; (
  input  addr_t                        addr_i,
  input  rt_rule_t [`RT_NUM_RULES-1:0] rules_i,
  output region_idx_t                  idx_o,
  output logic                         dec_error_o
);

  always_comb begin
    idx_o       = '0;
    dec_error_o = 1'b1;
    // later rules override earlier ones
    for (int unsigned i = 0; i < `RT_NUM_RULES; i++) begin
      if ((addr_i >= rules_i[i].start_addr) && (addr_i < rules_i[i].end_addr)) begin
        idx_o       = rules_i[i].idx;
        dec_error_o = 1'b0;
      end
    end
  end

endmodule

//--- rt_budget_bank.sv
/*
  byte probe on the master port and the per-region budget counters
  a fragment with a decode error is flagged for its direction and not charged
  isolate_o is combinational on the counter state
*/
`timescale 1ns/1ns
`include "rt_settings.svh"

module rt_budget_bank import rt_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          enable_i,
  input  logic                          abort_i,
  input  logic                          mst_valid_i,
  input  logic                          mst_ready_i,
  input  len_t                          mst_len_i,
  input  size_t                         mst_size_i,
  input  logic                          mst_write_i,
  input  region_idx_t                   region_i,
  input  logic                          dec_error_i,
  input  budget_t [`RT_NUM_REGIONS-1:0] w_budget_i,
  input  period_t [`RT_NUM_REGIONS-1:0] w_period_i,
  input  budget_t [`RT_NUM_REGIONS-1:0] r_budget_i,
  input  period_t [`RT_NUM_REGIONS-1:0] r_period_i,
  output budget_t [`RT_NUM_REGIONS-1:0] w_budget_left_o,
  output period_t [`RT_NUM_REGIONS-1:0] w_period_left_o,
  output budget_t [`RT_NUM_REGIONS-1:0] r_budget_left_o,
  output period_t [`RT_NUM_REGIONS-1:0] r_period_left_o,
  output logic                          w_decode_error_o,
  output logic                          r_decode_error_o,
  output logic                          isolate_o
);

  ax_bytes_t                  bytes;
  logic                       charge;
  logic [`RT_NUM_REGIONS-1:0] w_spent;
  logic [`RT_NUM_REGIONS-1:0] r_spent;

  // --------------------
  // probe
  // --------------------
  assign bytes  = (ax_bytes_t'(mst_len_i) + 1'b1) << mst_size_i;
  assign charge = mst_valid_i & mst_ready_i & ~dec_error_i;

  assign w_decode_error_o = mst_valid_i & mst_write_i & dec_error_i;
  assign r_decode_error_o = mst_valid_i & ~mst_write_i & dec_error_i;

  assign isolate_o = enable_i & ((|w_spent) | (|r_spent));

  // --------------------
  // counters
  // --------------------
  for (genvar r = 0; r < `RT_NUM_REGIONS; r++) begin : gen_region
    logic sel;

    assign sel = charge & (region_i == region_idx_t'(r));

    rt_budget_counter write_counter_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .enable_i      (enable_i),
      .abort_i       (abort_i),
      .charge_i      (sel & mst_write_i),
      .bytes_i       (bytes),
      .budget_i      (w_budget_i[r]),
      .budget_left_o (w_budget_left_o[r]),
      .period_i      (w_period_i[r]),
      .period_left_o (w_period_left_o[r]),
      .spent_o       (w_spent[r])
    );

    rt_budget_counter read_counter_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .enable_i      (enable_i),
      .abort_i       (abort_i),
      .charge_i      (sel & ~mst_write_i),
      .bytes_i       (bytes),
      .budget_i      (r_budget_i[r]),
      .budget_left_o (r_budget_left_o[r]),
      .period_i      (r_period_i[r]),
      .period_left_o (r_period_left_o[r]),
      .spent_o       (r_spent[r])
    );
  end

endmodule

//--- rt_budget_counter.sv
/*
  period and byte budget for one region and direction
  both counters start at zero and reload on the first cycle out of reset
  a reload wins over a charge on the same edge
*/
`timescale 1ns/1ns

module rt_budget_counter import rt_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      enable_i,
  input  logic      abort_i,
  input  logic      charge_i,
  input  ax_bytes_t bytes_i,
  input  budget_t   budget_i,
  output budget_t   budget_left_o,
  input  period_t   period_i,
  output period_t   period_left_o,
  output logic      spent_o
);

  logic    reload;
  logic    charge_en;
  budget_t bytes;

  assign reload    = (period_left_o == '0) | abort_i;
  assign spent_o   = (budget_left_o == '0);
  assign charge_en = enable_i & charge_i & ~spent_o;
  assign bytes     = budget_t'(bytes_i);

  // --------------------
  // period
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      period_left_o <= '0;
    end else if (reload) begin
      period_left_o <= period_i;
    end else if (enable_i) begin
      period_left_o <= period_left_o - 1'b1;
    end
  end

  // --------------------
  // budget
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      budget_left_o <= '0;
    end else if (reload) begin
      budget_left_o <= budget_i;
    end else if (charge_en) begin
      // clamp at zero on overdraw
      budget_left_o <= (bytes > budget_left_o) ? '0 : budget_left_o - bytes;
    end
  end

endmodule

//--- rt_burst_splitter.sv
/*
  splits incrementing bursts into fragments of at most len_limit_i+1 beats
  the limit is sampled when a request is accepted
  one request at a time, the next is taken after its last fragment
*/
`timescale 1ns/1ns
`include "rt_settings.svh"

module rt_burst_splitter import rt_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  len_t  len_limit_i,
  input  logic  slv_valid_i,
  output logic  slv_ready_o,
  input  addr_t slv_addr_i,
  input  len_t  slv_len_i,
  input  size_t slv_size_i,
  input  logic  slv_write_i,
  output logic  mst_valid_o,
  input  logic  mst_ready_i,
  output addr_t mst_addr_o,
  output len_t  mst_len_o,
  output size_t mst_size_o,
  output logic  mst_write_o,
  output logic  busy_o
);

  split_state_e              state_q;
  split_state_e              state_d;
  logic                      ready_q;
  addr_t                     addr_q;
  size_t                     size_q;
  logic                      write_q;
  len_t                      limit_q;
  // beats still to send, up to 256
  logic [`RT_LEN_WIDTH:0]    beats_q;
  logic [`RT_LEN_WIDTH:0]    limit_beats;
  logic                      accept;
  logic                      hs;
  logic                      last;

  assign accept      = slv_valid_i & ready_q;
  assign hs          = mst_valid_o & mst_ready_i;
  assign limit_beats = {1'b0, limit_q} + 1'b1;
  assign last        = (beats_q <= limit_beats);

  // --------------------
  // FSM
  // --------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      SPLIT_IDLE: begin
        if (accept) begin
          state_d = SPLIT_BUSY;
        end
      end
      SPLIT_BUSY: begin
        if (hs && last) begin
          state_d = SPLIT_IDLE;
        end
      end
      default: begin
        state_d = SPLIT_IDLE;
      end
    endcase
  end

  // ready follows the state, held low through reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= SPLIT_IDLE;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == SPLIT_IDLE);
    end
  end

  // --------------------
  // burst registers
  // --------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= slv_addr_i;
      size_q  <= slv_size_i;
      write_q <= slv_write_i;
      limit_q <= len_limit_i;
      beats_q <= {1'b0, slv_len_i} + 1'b1;
    end else if (hs && !last) begin
      // step past a full fragment
      addr_q  <= addr_q + (addr_t'(limit_beats) << size_q);
      beats_q <= beats_q - limit_beats;
    end
  end

  assign slv_ready_o = ready_q;
  assign busy_o      = (state_q == SPLIT_BUSY);
  assign mst_valid_o = busy_o;
  assign mst_addr_o  = addr_q;
  assign mst_len_o   = last ? len_t'(beats_q - 1'b1) : limit_q;
  assign mst_size_o  = size_q;
  assign mst_write_o = write_q;

  // fragment held until the master side takes it
  a_mst_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst_valid_o && !mst_ready_i) |=> (mst_valid_o &&
      $stable({mst_addr_o, mst_len_o, mst_size_o, mst_write_o})))
    else $error("fragment changed under back-pressure, addr 0x%08h", mst_addr_o);

endmodule

//--- rt_isolate.sv
/*
  request gate with an outstanding fragment count
  the gate is combinational, isolated_o drops together with isolate_i
  downstream must not hold more than RT_MAX_PENDING fragments in flight
*/
`timescale 1ns/1ns
`include "rt_settings.svh"

module rt_isolate import rt_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     isolate_i,
  input  logic     slv_valid_i,
  output logic     slv_ready_o,
  output logic     gated_valid_o,
  input  logic     gated_ready_i,
  input  logic     split_busy_i,
  input  logic     mst_valid_i,
  input  logic     mst_ready_i,
  input  logic     mst_done_i,
  output pending_t num_pending_o,
  output logic     isolated_o
);

  iso_state_e state_q;
  iso_state_e state_d;
  logic       issue;
  logic       drained;

  // --------------------
  // request gate
  // --------------------
  assign gated_valid_o = slv_valid_i & ~isolate_i;
  assign slv_ready_o   = gated_ready_i & ~isolate_i;

  // --------------------
  // pending fragments
  // --------------------
  assign issue = mst_valid_i & mst_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      num_pending_o <= '0;
    end else if (issue && !mst_done_i) begin
      num_pending_o <= num_pending_o + 1'b1;
    end else if (!issue && mst_done_i) begin
      num_pending_o <= num_pending_o - 1'b1;
    end
  end

  // --------------------
  // isolation FSM
  // --------------------
  // nothing in flight and no burst half split
  assign drained = (num_pending_o == '0) && !split_busy_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ISO_OPEN: begin
        if (isolate_i) begin
          state_d = drained ? ISO_CLOSED : ISO_DRAIN;
        end
      end
      ISO_DRAIN: begin
        if (!isolate_i) begin
          state_d = ISO_OPEN;
        end else if (drained) begin
          state_d = ISO_CLOSED;
        end
      end
      ISO_CLOSED: begin
        if (!isolate_i) begin
          state_d = ISO_OPEN;
        end
      end
      default: begin
        state_d = ISO_OPEN;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ISO_OPEN;
    end else begin
      state_q <= state_d;
    end
  end

  assign isolated_o = (state_q == ISO_CLOSED) & isolate_i;

  // completions only for fragments that went out
  a_done_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_done_i |-> (num_pending_o != '0))
    else $error("completion pulse with no fragment pending");

  a_pending_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    num_pending_o <= `RT_MAX_PENDING)
    else $error("pending count 0x%0h above limit", num_pending_o);

endmodule

//--- rt_pkg.sv
/*
  types shared by the regulator stages
  a rule covers [start_addr, end_addr)
  ax_bytes_t holds fragments below 4 KiB; larger ones are charged modulo 4 KiB
*/
`include "rt_settings.svh"

package rt_pkg;

  typedef logic [`RT_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`RT_LEN_WIDTH-1:0]  len_t;
  typedef logic [`RT_SIZE_WIDTH-1:0] size_t;

  // byte count of one fragment
  typedef logic [`RT_LEN_WIDTH+`RT_SIZE_WIDTH:0] ax_bytes_t;

  typedef logic [$clog2(`RT_NUM_REGIONS)-1:0]   region_idx_t;
  typedef logic [`RT_PERIOD_WIDTH-1:0]          period_t;
  typedef logic [`RT_BUDGET_WIDTH-1:0]          budget_t;
  typedef logic [$clog2(`RT_MAX_PENDING+1)-1:0] pending_t;

  typedef struct packed {
    region_idx_t idx;
    addr_t       start_addr;
    addr_t       end_addr;
  } rt_rule_t;

  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_BUSY
  } split_state_e;

  typedef enum logic [1:0] {
    ISO_OPEN,
    ISO_DRAIN,
    ISO_CLOSED
  } iso_state_e;

endpackage

//--- rt_settings.svh
/*
  widths and counts shared by the bandwidth regulator RTL
  lengths follow AXI, so a burst carries len+1 beats
  RT_NUM_REGIONS must be at least two for the region index to have a width
*/
`ifndef RT_SETTINGS_SVH
`define RT_SETTINGS_SVH

// request fields
`define RT_ADDR_WIDTH   32
`define RT_LEN_WIDTH    8
`define RT_SIZE_WIDTH   3

// address map
`define RT_NUM_REGIONS  4
`define RT_NUM_RULES    4

// budget bookkeeping
`define RT_PERIOD_WIDTH 32
`define RT_BUDGET_WIDTH 32

// fragments allowed in flight downstream
`define RT_MAX_PENDING  16

`endif

//--- rt_unit.sv
/*
  bandwidth regulator top: gate, splitter, decoder and budget bank
  only the request channel is modelled, mst_done_i pulses once per fragment
  control inputs are plain levels and may change at any cycle
*/
`timescale 1ns/1ns
`include "rt_settings.svh"

module rt_unit import rt_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // slave port
  input  logic                          slv_valid_i,
  output logic                          slv_ready_o,
  input  addr_t                         slv_addr_i,
  input  len_t                          slv_len_i,
  input  size_t                         slv_size_i,
  input  logic                          slv_write_i,
  // master port
  output logic                          mst_valid_o,
  input  logic                          mst_ready_i,
  output addr_t                         mst_addr_o,
  output len_t                          mst_len_o,
  output size_t                         mst_size_o,
  output logic                          mst_write_o,
  input  logic                          mst_done_i,
  // control
  input  len_t                          len_limit_i,
  input  rt_rule_t [`RT_NUM_RULES-1:0]  rules_i,
  input  logic                          imtu_enable_i,
  input  logic                          imtu_abort_i,
  input  budget_t [`RT_NUM_REGIONS-1:0] w_budget_i,
  input  period_t [`RT_NUM_REGIONS-1:0] w_period_i,
  input  budget_t [`RT_NUM_REGIONS-1:0] r_budget_i,
  input  period_t [`RT_NUM_REGIONS-1:0] r_period_i,
  // status
  output budget_t [`RT_NUM_REGIONS-1:0] w_budget_left_o,
  output period_t [`RT_NUM_REGIONS-1:0] w_period_left_o,
  output budget_t [`RT_NUM_REGIONS-1:0] r_budget_left_o,
  output period_t [`RT_NUM_REGIONS-1:0] r_period_left_o,
  output logic                          w_decode_error_o,
  output logic                          r_decode_error_o,
  output pending_t                      num_pending_o,
  output logic                          isolate_o,
  output logic                          isolated_o
);

  logic        gated_valid;
  logic        gated_ready;
  logic        split_busy;
  logic        isolate;
  region_idx_t region;
  logic        dec_error;

  assign isolate_o = isolate;

  rt_isolate rt_isolate_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .isolate_i     (isolate),
    .slv_valid_i   (slv_valid_i),
    .slv_ready_o   (slv_ready_o),
    .gated_valid_o (gated_valid),
    .gated_ready_i (gated_ready),
    .split_busy_i  (split_busy),
    .mst_valid_i   (mst_valid_o),
    .mst_ready_i   (mst_ready_i),
    .mst_done_i    (mst_done_i),
    .num_pending_o (num_pending_o),
    .isolated_o    (isolated_o)
  );

  rt_burst_splitter rt_burst_splitter_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .len_limit_i (len_limit_i),
    .slv_valid_i (gated_valid),
    .slv_ready_o (gated_ready),
    .slv_addr_i  (slv_addr_i),
    .slv_len_i   (slv_len_i),
    .slv_size_i  (slv_size_i),
    .slv_write_i (slv_write_i),
    .mst_valid_o (mst_valid_o),
    .mst_ready_i (mst_ready_i),
    .mst_addr_o  (mst_addr_o),
    .mst_len_o   (mst_len_o),
    .mst_size_o  (mst_size_o),
    .mst_write_o (mst_write_o),
    .busy_o      (split_busy)
  );

  rt_addr_decode rt_addr_decode_i (
    .addr_i      (mst_addr_o),
    .rules_i     (rules_i),
    .idx_o       (region),
    .dec_error_o (dec_error)
  );

  rt_budget_bank rt_budget_bank_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .enable_i         (imtu_enable_i),
    .abort_i          (imtu_abort_i),
    .mst_valid_i      (mst_valid_o),
    .mst_ready_i      (mst_ready_i),
    .mst_len_i        (mst_len_o),
    .mst_size_i       (mst_size_o),
    .mst_write_i      (mst_write_o),
    .region_i         (region),
    .dec_error_i      (dec_error),
    .w_budget_i       (w_budget_i),
    .w_period_i       (w_period_i),
    .r_budget_i       (r_budget_i),
    .r_period_i       (r_period_i),
    .w_budget_left_o  (w_budget_left_o),
    .w_period_left_o  (w_period_left_o),
    .r_budget_left_o  (r_budget_left_o),
    .r_period_left_o  (r_period_left_o),
    .w_decode_error_o (w_decode_error_o),
    .r_decode_error_o (r_decode_error_o),
    .isolate_o        (isolate)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the regulator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_rt_unit -o sim_tb_rt_unit \
  && ./obj_dir/sim_tb_rt_unit | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb_rt_unit.sv
/*
  testbench for the bandwidth regulator top level
  a reference model mirrors the fragment queue, budgets, periods and isolation
  sizes stay below 3 so a fragment never reaches 4 KiB
*/
`timescale 1ns/1ns
`include "rt_settings.svh"

module tb_rt_unit import rt_pkg::*; ();

  localparam int unsigned N_RAND = 40;
  localparam int unsigned N_OFF  = 10;
  // worst request is 64 single-beat fragments at about half ready
  localparam int unsigned SCHED  = (N_RAND + N_OFF + 2) * 160 + 600;
  localparam int unsigned LIMIT  = 2 * SCHED;
  localparam logic [31:0] SEED   = 32'h9bf3_1345;

  typedef struct packed {
    addr_t addr;
    len_t  len;
    size_t size;
    logic  write;
  } frag_t;

  logic clk_i, rst_n_i, slv_valid_i, slv_ready_o, slv_write_i, mst_valid_o, mst_ready_i;
  logic mst_write_o, mst_done_i, imtu_enable_i, imtu_abort_i;
  logic w_decode_error_o, r_decode_error_o, isolate_o, isolated_o;
  addr_t slv_addr_i, mst_addr_o;
  len_t slv_len_i, mst_len_o, len_limit_i;
  size_t slv_size_i, mst_size_o;
  rt_rule_t [`RT_NUM_RULES-1:0] rules_i;
  budget_t [`RT_NUM_REGIONS-1:0] w_budget_i, r_budget_i, w_budget_left_o, r_budget_left_o;
  period_t [`RT_NUM_REGIONS-1:0] w_period_i, r_period_i, w_period_left_o, r_period_left_o;
  pending_t num_pending_o;

  // model state
  frag_t frag_q[$];
  frag_t head;
  logic head_err;
  region_idx_t head_idx;
  int m_qsize, m_pending;
  logic m_closed, m_any_spent;
  budget_t [`RT_NUM_REGIONS-1:0] m_w_budget, m_r_budget;
  period_t [`RT_NUM_REGIONS-1:0] m_w_period, m_r_period;
  logic [31:0] lfsr_main, lfsr_bg;
  int unsigned cycles = 0;

  rt_unit rt_unit_i (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_main = lfsr_step(lfsr_main);
      v = {v[30:0], lfsr_main[0]};
    end
    return v;
  endfunction

  // {error, region}, the last matching rule wins
  function automatic logic [$bits(region_idx_t):0] decode_addr(input addr_t a);
    logic err;
    region_idx_t idx;
    err = 1'b1;
    idx = '0;
    for (int i = 0; i < `RT_NUM_RULES; i++) begin
      if (a >= rules_i[i].start_addr && a < rules_i[i].end_addr) begin
        err = 1'b0;
        idx = rules_i[i].idx;
      end
    end
    return {err, idx};
  endfunction

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // --------------------
  // clock and timeout
  // --------------------
  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      stop_run();
    end
  end

  // --------------------
  // reference model
  // --------------------
  always @(posedge clk_i) begin
    logic hs, reload, drained, iso_now;
    ax_bytes_t bytes;
    addr_t a;
    int beats, lb, n;
    if (!rst_n_i) begin
      frag_q.delete();
      m_pending = 0;
      m_closed = 1'b0;
      m_w_budget = '0;
      m_r_budget = '0;
      m_w_period = '0;
      m_r_period = '0;
    end else begin
      iso_now = imtu_enable_i & m_any_spent;
      drained = (m_pending == 0) && (frag_q.size() == 0);
      m_closed = iso_now && (m_closed || drained);
      hs = mst_valid_o && mst_ready_i;
      if (hs && !mst_done_i) m_pending++;
      else if (!hs && mst_done_i) m_pending--;
      bytes = (ax_bytes_t'(head.len) + 1) << head.size;
      for (int r = 0; r < `RT_NUM_REGIONS; r++) begin
        reload = (m_w_period[r] == 0) || imtu_abort_i;
        if (reload) m_w_budget[r] = w_budget_i[r];
        else if (imtu_enable_i && hs && !head_err && head_idx == r && head.write &&
                 m_w_budget[r] != 0)
          m_w_budget[r] = (bytes > m_w_budget[r]) ? '0 : m_w_budget[r] - bytes;
        if (reload) m_w_period[r] = w_period_i[r];
        else if (imtu_enable_i) m_w_period[r] = m_w_period[r] - 1;
        reload = (m_r_period[r] == 0) || imtu_abort_i;
        if (reload) m_r_budget[r] = r_budget_i[r];
        else if (imtu_enable_i && hs && !head_err && head_idx == r && !head.write &&
                 m_r_budget[r] != 0)
          m_r_budget[r] = (bytes > m_r_budget[r]) ? '0 : m_r_budget[r] - bytes;
        if (reload) m_r_period[r] = r_period_i[r];
        else if (imtu_enable_i) m_r_period[r] = m_r_period[r] - 1;
      end
      if (hs && frag_q.size() > 0) void'(frag_q.pop_front());
      // split an accepted request into limit-sized fragments
      if (slv_valid_i && slv_ready_o) begin
        a = slv_addr_i;
        beats = int'(slv_len_i) + 1;
        lb = int'(len_limit_i) + 1;
        while (beats > 0) begin
          n = (beats < lb) ? beats : lb;
          frag_q.push_back('{a, len_t'(n - 1), slv_size_i, slv_write_i});
          a = a + (addr_t'(n) << slv_size_i);
          beats = beats - n;
        end
      end
    end
    m_qsize = frag_q.size();
    if (m_qsize > 0) head = frag_q[0];
    {head_err, head_idx} = decode_addr(head.addr);
    m_any_spent = 1'b0;
    for (int r = 0; r < `RT_NUM_REGIONS; r++) begin
      m_any_spent |= (m_w_budget[r] == 0) || (m_r_budget[r] == 0);
    end
  end

  // --------------------
  // checks
  // --------------------
  a_frag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_valid_o |-> (m_qsize > 0 && {mst_addr_o, mst_len_o, mst_size_o, mst_write_o} == head))
    else begin
      $write("[ERROR] mst_addr_o/len/size/write 0x%08h/0x%02h/0x%0h/0x%0h",
             mst_addr_o, mst_len_o, mst_size_o, mst_write_o);
      $display(" exp 0x%08h/0x%02h/0x%0h/0x%0h", head.addr, head.len, head.size, head.write);
      stop_run();
    end
  a_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_valid_i && slv_ready_o) |-> (m_qsize == 0))
    else begin
      $display("request accepted while fragments of the previous one were still queued");
      stop_run();
    end
  a_decode: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    {w_decode_error_o, r_decode_error_o} ==
      {mst_valid_o & head_err & head.write, mst_valid_o & head_err & ~head.write})
    else begin
      $display("[ERROR] w/r_decode_error_o 0x%0h/0x%0h exp 0x%0h/0x%0h, addr 0x%08h",
               w_decode_error_o, r_decode_error_o, mst_valid_o & head_err & head.write,
               mst_valid_o & head_err & ~head.write, mst_addr_o);
      stop_run();
    end
  a_budget: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_budget_left_o == m_w_budget && r_budget_left_o == m_r_budget)
    else begin
      $display("[ERROR] w_budget_left_o 0x%0h exp 0x%0h, r_budget_left_o 0x%0h exp 0x%0h",
               w_budget_left_o, m_w_budget, r_budget_left_o, m_r_budget);
      stop_run();
    end
  a_period: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_period_left_o == m_w_period && r_period_left_o == m_r_period)
    else begin
      $display("[ERROR] w_period_left_o 0x%0h exp 0x%0h, r_period_left_o 0x%0h exp 0x%0h",
               w_period_left_o, m_w_period, r_period_left_o, m_r_period);
      stop_run();
    end
  a_isolate: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    isolate_o == (imtu_enable_i & m_any_spent) && !(isolate_o && slv_ready_o))
    else begin
      $display("[ERROR] isolate_o 0x%0h exp 0x%0h, slv_ready_o 0x%0h",
               isolate_o, imtu_enable_i & m_any_spent, slv_ready_o);
      stop_run();
    end
  a_isolated: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    isolated_o == (m_closed & imtu_enable_i & m_any_spent) &&
      num_pending_o == pending_t'(m_pending))
    else begin
      $display("[ERROR] isolated_o 0x%0h exp 0x%0h, num_pending_o 0x%0h exp 0x%0h",
               isolated_o, m_closed & imtu_enable_i & m_any_spent, num_pending_o, m_pending);
      stop_run();
    end

  // --------------------
  // stimulus
  // --------------------
  task automatic send_request(input addr_t a, input len_t l, input size_t s, input logic w,
                              input len_t lim);
    slv_valid_i = 1'b1;
    slv_addr_i  = a;
    slv_len_i   = l;
    slv_size_i  = s;
    slv_write_i = w;
    len_limit_i = lim;
    do @(posedge clk_i); while (!slv_ready_o);
    #1 slv_valid_i = 1'b0;
  endtask

  task automatic random_request();
    logic [1:0] reg_sel;
    size_t s;
    addr_t a;
    reg_sel = 2'(take_bits(2));
    s = size_t'(take_bits(2) % 3);
    a = addr_t'(reg_sel) * 32'h1000 + (addr_t'(take_bits(10)) << s);
    // roughly one in eight misses every rule
    if (take_bits(3) == 0) a = a | 32'h8000;
    send_request(a, len_t'(take_bits(6)), s, take_bits(1) != 0, len_t'(take_bits(4)));
  endtask

  // sampled a step after the edge, when the model is settled
  task automatic wait_drain();
    while (m_qsize != 0 || m_pending != 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // random back-pressure and completions
  initial begin
    logic done_bit;
    lfsr_bg = SEED;
    forever begin
      @(posedge clk_i);
      #1;
      lfsr_bg = lfsr_step(lfsr_bg);
      mst_ready_i = lfsr_bg[0];
      lfsr_bg = lfsr_step(lfsr_bg);
      done_bit = lfsr_bg[0];
      lfsr_bg = lfsr_step(lfsr_bg);
      mst_done_i = (m_pending > 0) && rst_n_i && (done_bit | lfsr_bg[0]);
    end
  end

  initial begin
    lfsr_main = SEED;
    {rst_n_i, slv_valid_i, slv_write_i, mst_ready_i, mst_done_i} = '0;
    {imtu_enable_i, imtu_abort_i} = '0;
    slv_addr_i = '0;
    slv_len_i = '0;
    slv_size_i = '0;
    len_limit_i = '0;
    for (int i = 0; i < `RT_NUM_RULES; i++) begin
      rules_i[i] = '{region_idx_t'(i), addr_t'(i * 32'h1000), addr_t'((i + 1) * 32'h1000)};
      w_budget_i[i] = 32'h1_0000;
      r_budget_i[i] = 32'h1_0000;
      w_period_i[i] = 300;
      r_period_i[i] = 300 + i;
    end
    repeat (8) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    imtu_enable_i = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      random_request();
      if (i == N_RAND / 2) begin
        imtu_abort_i = 1'b1;
        @(posedge clk_i);
        #1 imtu_abort_i = 1'b0;
      end
    end
    // earlier fragments must not touch the small budget
    wait_drain();
    // small write budget on region 1, overdrawn by one burst
    w_budget_i[1] = 64;
    for (int i = 0; i < `RT_NUM_REGIONS; i++) begin
      w_period_i[i] = 100000;
      r_period_i[i] = 100000;
    end
    imtu_abort_i = 1'b1;
    @(posedge clk_i);
    #1 imtu_abort_i = 1'b0;
    send_request(32'h1000, 8'd31, 3'd2, 1'b1, 8'd7);
    while (!isolated_o) @(posedge clk_i);
    // same burst again, held at the closed gate
    #1 slv_valid_i = 1'b1;
    repeat (20) @(posedge clk_i);
    #1 w_budget_i[1] = 32'h1_0000;
    imtu_abort_i = 1'b1;
    @(posedge clk_i);
    #1 imtu_abort_i = 1'b0;
    send_request(32'h1000, 8'd31, 3'd2, 1'b1, 8'd7);
    send_request(32'h2000, 8'd3, 3'd1, 1'b0, 8'd1);
    // regulation off
    imtu_enable_i = 1'b0;
    for (int i = 0; i < N_OFF; i++) begin
      random_request();
    end
    wait_drain();
    repeat (4) @(posedge clk_i);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
